// ==== cp0_defines.svh ====
`ifndef CP0_DEFINES_SVH
`define CP0_DEFINES_SVH

`define TLB_ENTRIES_NUM 16
`define COMPILE_FULL 1

`define EXCCODE_INT  5'h00
`define EXCCODE_MOD  5'h01
`define EXCCODE_TLBL 5'h02
`define EXCCODE_TLBS 5'h03
`define EXCCODE_ADEL 5'h04
`define EXCCODE_ADES 5'h05
`define EXCCODE_SYS  5'h08

// cache sizes in bits, line widths in bits
`define ICACHE_SIZE       (16 * 1024 * 8)
`define ICACHE_SET_ASSOC  2
`define ICACHE_LINE_WIDTH 256
`define DCACHE_SIZE       (16 * 1024 * 8)
`define DCACHE_SET_ASSOC  2
`define DCACHE_LINE_WIDTH 256

`define STATUS_RESET  32'h1040_0000
`define EBASE_RESET   32'h8000_0000
`define PRID_RESET    32'h0001_8000
`define CONFIG0_RESET 32'h8000_0083

`endif

// ==== cp0_pkg.sv ====
`default_nettype none

package cp0_pkg;

	typedef logic [31:0] uint32_t;
	typedef logic [4:0]  reg_addr_t;

	typedef struct packed {
		logic      we;
		reg_addr_t waddr;
		logic [2:0] wsel;
		uint32_t   wdata;
	} cp0_req_t;

	typedef struct packed {
		logic       valid;
		logic       eret;
		logic       delayslot;
		logic [4:0] code;
		uint32_t    pc;
		uint32_t    extra; // faulting address.
	} except_req_t;

	typedef struct packed {
		logic [18:0] vpn2;
		logic [7:0]  asid;
		logic        G;
		logic [23:0] pfn1;
		logic [2:0]  c1;
		logic        d1;
		logic        v1;
		logic [23:0] pfn0;
		logic [2:0]  c0;
		logic        d0;
		logic        v0;
	} tlb_entry_t;

	typedef union packed {
		uint32_t raw;
		struct packed {
			logic [2:0] cu_hi;
			logic       cu0;
			logic [4:0] rsvd0;
			logic       bev;
			logic [5:0] rsvd1;
			logic [7:0] im;
			logic [2:0] rsvd2;
			logic       um;
			logic       rsvd3;
			logic       erl;
			logic       exl;
			logic       ie;
		} f;
	} cp0_status_u;

	typedef union packed {
		uint32_t raw;
		struct packed {
			logic       bd;
			logic [6:0] rsvd0;
			logic       iv;
			logic [6:0] rsvd1;
			logic [7:0] ip;
			logic       rsvd2;
			logic [4:0] exc_code;
			logic [1:0] rsvd3;
		} f;
	} cp0_cause_u;

	typedef struct packed {
		uint32_t     index;
		uint32_t     random;
		uint32_t     entry_lo0;
		uint32_t     entry_lo1;
		uint32_t     context_;
		uint32_t     page_mask;
		uint32_t     wired;
		uint32_t     bad_vaddr;
		uint32_t     count;
		uint32_t     entry_hi;
		uint32_t     compare;
		cp0_status_u status;
		cp0_cause_u  cause;
		uint32_t     epc;
		uint32_t     prid;
		uint32_t     ebase;
		uint32_t     config0;
		uint32_t     config1;
		uint32_t     error_epc;
	} cp0_regs_t;

endpackage

`default_nettype wire

// ==== cp0_tlb_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface cp0_tlb_if;

	// strobes come from instruction decode at the top level.
	logic tlbr_req;
	logic tlbp_req;
	logic tlbwi_req;
	logic tlbwr_req;

	cp0_pkg::tlb_entry_t wdata; // built from entryhi/entrylo.
	cp0_pkg::uint32_t    index;
	cp0_pkg::uint32_t    random;

	cp0_pkg::tlb_entry_t tlbr_res;
	cp0_pkg::uint32_t    tlbp_res; // bit 31 set on miss.

	modport cp0 (
		input  tlbr_req, tlbp_req, tlbwr_req,
		input  tlbr_res, tlbp_res,
		output wdata, index, random
	);

	modport tlb (
		input  tlbr_req, tlbp_req, tlbwi_req, tlbwr_req,
		input  wdata, index, random,
		output tlbr_res, tlbp_res
	);

endinterface

`default_nettype wire

// ==== cp0.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cp0_defines.svh"

module cp0 (
	input  logic                  clk,
	input  logic                  rst,
	input  cp0_pkg::reg_addr_t    raddr,
	input  logic [2:0]            rsel,
	input  cp0_pkg::cp0_req_t     wreq,
	input  cp0_pkg::except_req_t  except_req_i,
	input  logic [7:0]            interrupt_flag,
	cp0_tlb_if.cp0                tlb,
	output cp0_pkg::uint32_t      rdata,
	output cp0_pkg::cp0_regs_t    regs,
	output logic [7:0]            asid,
	output logic                  user_mode,
	output logic                  kseg0_uncached,
	output logic                  timer_int
);

	localparam int TLB_WIDTH = $clog2(`TLB_ENTRIES_NUM);

	localparam int IC_SETS  = $clog2(`ICACHE_SIZE / `ICACHE_SET_ASSOC / `ICACHE_LINE_WIDTH / 64);
	localparam int IC_LINE  = $clog2(`ICACHE_LINE_WIDTH / 32) + 1;
	localparam int IC_ASSOC = `ICACHE_SET_ASSOC - 1;
	localparam int DC_SETS  = $clog2(`DCACHE_SIZE / `DCACHE_SET_ASSOC / `DCACHE_LINE_WIDTH / 64);
	localparam int DC_LINE  = $clog2(`DCACHE_LINE_WIDTH / 32) + 1;
	localparam int DC_ASSOC = `DCACHE_SET_ASSOC - 1;

	localparam logic [31:0] CONFIG1_RESET = {
		1'b0,
		6'(`TLB_ENTRIES_NUM - 1), // mmu size minus one.
		IC_SETS[2:0], IC_LINE[2:0], IC_ASSOC[2:0],
		DC_SETS[2:0], DC_LINE[2:0], DC_ASSOC[2:0],
		7'd0
	};

	cp0_pkg::cp0_regs_t   regs_q, regs_d;
	cp0_pkg::except_req_t except_req;
	cp0_pkg::uint32_t     rdata_d;
	cp0_pkg::uint32_t     wdata;
	logic                 count_tick;
	logic                 compare_wr;

	assign regs  = regs_q;
	assign wdata = wreq.wdata;

	assign asid           = `COMPILE_FULL ? regs_q.entry_hi[7:0] : 8'd0;
	assign user_mode      = `COMPILE_FULL ? (regs_q.status.raw[4:1] == 4'b1000) : 1'b0;
	assign kseg0_uncached = `COMPILE_FULL ? (regs_q.config0[2:0] == 3'd2) : 1'b0;

	assign tlb.index  = regs_q.index;
	assign tlb.random = regs_q.random;
	assign tlb.wdata  = '{
		vpn2: regs_q.entry_hi[31:13],
		asid: regs_q.entry_hi[7:0],
		G:    regs_q.entry_lo0[0] & regs_q.entry_lo1[0],
		pfn1: regs_q.entry_lo1[29:6],
		c1:   regs_q.entry_lo1[5:3],
		d1:   regs_q.entry_lo1[2],
		v1:   regs_q.entry_lo1[1],
		pfn0: regs_q.entry_lo0[29:6],
		c0:   regs_q.entry_lo0[5:3],
		d0:   regs_q.entry_lo0[2],
		v0:   regs_q.entry_lo0[1]
	};

	always_ff @(posedge clk) begin
		if (rst)
			except_req <= '0;
		else
			except_req <= except_req_i; // applied one cycle later.
	end

	always_comb begin
		rdata_d = 32'd0;
		if (rsel == 3'd0) begin
			case (raddr)
				5'd0:  rdata_d = regs_q.index;
				5'd1:  rdata_d = regs_q.random;
				5'd2:  rdata_d = regs_q.entry_lo0;
				5'd3:  rdata_d = regs_q.entry_lo1;
				5'd4:  rdata_d = regs_q.context_;
				5'd5:  rdata_d = regs_q.page_mask;
				5'd6:  rdata_d = regs_q.wired;
				5'd8:  rdata_d = regs_q.bad_vaddr;
				5'd9:  rdata_d = regs_q.count;
				5'd10: rdata_d = regs_q.entry_hi;
				5'd11: rdata_d = regs_q.compare;
				5'd12: rdata_d = regs_q.status.raw;
				5'd13: rdata_d = regs_q.cause.raw;
				5'd14: rdata_d = regs_q.epc;
				5'd15: rdata_d = regs_q.prid;
				5'd16: rdata_d = regs_q.config0;
				5'd30: rdata_d = regs_q.error_epc;
				default: rdata_d = 32'd0;
			endcase
		end else if (rsel == 3'd1 && `COMPILE_FULL) begin
			case (raddr)
				5'd15: rdata_d = regs_q.ebase;
				5'd16: rdata_d = regs_q.config1;
				default: rdata_d = 32'd0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			rdata <= 32'd0;
		else
			rdata <= rdata_d;
	end

	always_ff @(posedge clk) begin
		if (rst)
			count_tick <= 1'b0;
		else
			count_tick <= ~count_tick; // count runs at half rate.
	end

	assign compare_wr = wreq.we && wreq.wsel == 3'd0 && wreq.waddr == 5'd11;

	always_ff @(posedge clk) begin
		if (rst)
			timer_int <= 1'b0;
		else if (compare_wr)
			timer_int <= 1'b0;
		else if (regs_q.compare != 32'd0 && regs_q.compare == regs_q.count)
			timer_int <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			regs_q           <= '0;
			regs_q.random    <= 32'(`TLB_ENTRIES_NUM - 1);
			regs_q.status    <= `STATUS_RESET;
			regs_q.ebase     <= `EBASE_RESET;
			regs_q.prid      <= `PRID_RESET;
			regs_q.config0   <= `CONFIG0_RESET;
			regs_q.config1   <= CONFIG1_RESET;
		end else begin
			regs_q <= regs_d;
		end
	end

	always_comb begin
		regs_d = regs_q;
		regs_d.count = regs_q.count + {31'd0, count_tick};
		regs_d.cause.f.ip[7:2] = interrupt_flag[7:2];

		if (`COMPILE_FULL && tlb.tlbwr_req) begin
			if (regs_q.random[TLB_WIDTH-1:0] == TLB_WIDTH'(`TLB_ENTRIES_NUM - 1))
				regs_d.random = regs_q.wired; // wrap to wired.
			else
				regs_d.random = regs_q.random + 32'd1;
		end

		if (wreq.we && wreq.wsel == 3'd0) begin
			case (wreq.waddr)
				5'd0:  regs_d.index[TLB_WIDTH-1:0] = wdata[TLB_WIDTH-1:0];
				5'd2:  regs_d.entry_lo0 = {2'b00, wdata[29:0]};
				5'd3:  regs_d.entry_lo1 = {2'b00, wdata[29:0]};
				5'd4:  regs_d.context_[31:23] = wdata[31:23]; // ptebase only.
				5'd6: begin
					regs_d.random = 32'(`TLB_ENTRIES_NUM - 1);
					regs_d.wired[TLB_WIDTH-1:0] = wdata[TLB_WIDTH-1:0];
				end
				5'd9:  regs_d.count = wdata;
				5'd10: begin
					regs_d.entry_hi[31:13] = wdata[31:13];
					regs_d.entry_hi[7:0]   = wdata[7:0];
				end
				5'd11: regs_d.compare = wdata;
				5'd12: begin
					regs_d.status.f.cu0 = wdata[28];
					regs_d.status.f.bev = wdata[22];
					regs_d.status.f.im  = wdata[15:8];
					regs_d.status.f.um  = wdata[4];
					regs_d.status.f.erl = wdata[2];
					regs_d.status.f.exl = wdata[1];
					regs_d.status.f.ie  = wdata[0];
				end
				5'd13: begin
					regs_d.cause.f.iv      = wdata[23];
					regs_d.cause.f.ip[1:0] = wdata[9:8]; // software interrupts.
				end
				5'd14: regs_d.epc = wdata;
				5'd16: regs_d.config0[2:0] = wdata[2:0];
				default: ;
			endcase
		end else if (wreq.we && wreq.wsel == 3'd1 && `COMPILE_FULL) begin
			if (wreq.waddr == 5'd15)
				regs_d.ebase[29:12] = wdata[29:12];
		end

		if (tlb.tlbr_req) begin
			regs_d.entry_hi[31:13] = tlb.tlbr_res.vpn2;
			regs_d.entry_hi[7:0]   = tlb.tlbr_res.asid;
			regs_d.entry_lo1 = {2'b00, tlb.tlbr_res.pfn1, tlb.tlbr_res.c1,
				tlb.tlbr_res.d1, tlb.tlbr_res.v1, tlb.tlbr_res.G};
			regs_d.entry_lo0 = {2'b00, tlb.tlbr_res.pfn0, tlb.tlbr_res.c0,
				tlb.tlbr_res.d0, tlb.tlbr_res.v0, tlb.tlbr_res.G};
		end

		if (tlb.tlbp_req)
			regs_d.index = tlb.tlbp_res;

		if (except_req.valid) begin
			if (except_req.eret) begin
				if (regs_d.status.f.erl)
					regs_d.status.f.erl = 1'b0;
				else
					regs_d.status.f.exl = 1'b0;
			end else begin
				if (!regs_d.status.f.exl) begin // nested exceptions keep epc.
					regs_d.epc       = except_req.delayslot ? except_req.pc - 32'd4
						: except_req.pc;
					regs_d.cause.f.bd = except_req.delayslot;
				end
				regs_d.status.f.exl     = 1'b1;
				regs_d.cause.f.exc_code = except_req.code;
				if (except_req.code == `EXCCODE_ADEL || except_req.code == `EXCCODE_ADES) begin
					regs_d.bad_vaddr = except_req.extra;
				end else if (except_req.code == `EXCCODE_TLBL ||
					except_req.code == `EXCCODE_TLBS || except_req.code == `EXCCODE_MOD) begin
					regs_d.bad_vaddr        = except_req.extra;
					regs_d.context_[22:4]   = except_req.extra[31:13]; // badvpn2.
					regs_d.entry_hi[31:13]  = except_req.extra[31:13];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tlb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cp0_defines.svh"

module tlb (
	input  logic             clk,
	input  logic             rst,
	cp0_tlb_if.tlb           bus,
	input  logic [7:0]       asid,
	input  logic             lookup_valid,
	input  cp0_pkg::uint32_t lookup_vaddr,
	output cp0_pkg::uint32_t lookup_paddr,
	output logic             lookup_hit,
	output logic             lookup_dirty
);

	localparam int TLB_WIDTH = $clog2(`TLB_ENTRIES_NUM);

	cp0_pkg::tlb_entry_t entries [`TLB_ENTRIES_NUM];

	logic                 probe_found;
	logic [TLB_WIDTH-1:0] probe_idx;
	logic                 look_found;
	logic [TLB_WIDTH-1:0] look_idx;
	cp0_pkg::tlb_entry_t  look_entry;
	logic [23:0]          page_pfn;
	logic                 page_d;
	logic                 page_v;

	// vpn2 match plus asid match unless global.
	function automatic logic entry_match(
		input cp0_pkg::tlb_entry_t e,
		input logic [18:0]         vpn2,
		input logic [7:0]          id
	);
		return e.vpn2 == vpn2 && (e.G || e.asid == id);
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `TLB_ENTRIES_NUM; i++)
				entries[i] <= '0; // all pages invalid.
		end else if (bus.tlbwi_req) begin
			entries[bus.index[TLB_WIDTH-1:0]] <= bus.wdata;
		end else if (bus.tlbwr_req) begin
			entries[bus.random[TLB_WIDTH-1:0]] <= bus.wdata;
		end
	end

	assign bus.tlbr_res = entries[bus.index[TLB_WIDTH-1:0]];

	always_comb begin
		probe_found = 1'b0;
		probe_idx   = '0;
		for (int i = `TLB_ENTRIES_NUM - 1; i >= 0; i--) begin
			if (entry_match(entries[i], bus.wdata.vpn2, bus.wdata.asid)) begin
				probe_found = 1'b1;
				probe_idx   = TLB_WIDTH'(i); // lowest index wins.
			end
		end
	end

	assign bus.tlbp_res = {~probe_found, {(31 - TLB_WIDTH){1'b0}}, probe_idx};

	always_comb begin
		look_found = 1'b0;
		look_idx   = '0;
		for (int i = `TLB_ENTRIES_NUM - 1; i >= 0; i--) begin
			if (entry_match(entries[i], lookup_vaddr[31:13], asid)) begin
				look_found = 1'b1;
				look_idx   = TLB_WIDTH'(i);
			end
		end
	end

	assign look_entry = entries[look_idx];
	assign page_pfn   = lookup_vaddr[12] ? look_entry.pfn1 : look_entry.pfn0; // odd page on bit 12.
	assign page_d     = lookup_vaddr[12] ? look_entry.d1 : look_entry.d0;
	assign page_v     = lookup_vaddr[12] ? look_entry.v1 : look_entry.v0;

	always_ff @(posedge clk) begin
		if (rst)
			lookup_hit <= 1'b0;
		else
			lookup_hit <= lookup_valid && look_found && page_v;
	end

	always_ff @(posedge clk) begin
		lookup_paddr <= {page_pfn[19:0], lookup_vaddr[11:0]};
		lookup_dirty <= page_d;
	end

endmodule

`default_nettype wire

// ==== cp0_tlb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cp0_tlb_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               we,
	input  cp0_pkg::reg_addr_t waddr,
	input  logic [2:0]         wsel,
	input  cp0_pkg::uint32_t   wdata,
	input  cp0_pkg::reg_addr_t raddr,
	input  logic [2:0]         rsel,
	output cp0_pkg::uint32_t   rdata,
	input  logic               exc_valid,
	input  logic               exc_eret,
	input  logic               exc_delayslot,
	input  logic [4:0]         exc_code,
	input  cp0_pkg::uint32_t   exc_pc,
	input  cp0_pkg::uint32_t   exc_extra,
	input  logic [7:0]         interrupt_flag,
	input  logic               tlbr,
	input  logic               tlbp,
	input  logic               tlbwi,
	input  logic               tlbwr,
	input  logic               lookup_valid,
	input  cp0_pkg::uint32_t   lookup_vaddr,
	output cp0_pkg::uint32_t   lookup_paddr,
	output logic               lookup_hit,
	output logic               lookup_dirty,
	output logic               timer_int,
	output logic [7:0]         asid,
	output logic               user_mode,
	output logic               kseg0_uncached,
	output cp0_pkg::uint32_t   epc,
	output cp0_pkg::uint32_t   status,
	output cp0_pkg::uint32_t   cause
);

	cp0_pkg::cp0_req_t    wreq;
	cp0_pkg::except_req_t except_req;
	cp0_pkg::cp0_regs_t   regs;

	cp0_tlb_if tlb_bus ();

	assign wreq = '{we: we, waddr: waddr, wsel: wsel, wdata: wdata};
	assign except_req = '{valid: exc_valid, eret: exc_eret, delayslot: exc_delayslot,
		code: exc_code, pc: exc_pc, extra: exc_extra};

	assign tlb_bus.tlbr_req  = tlbr;
	assign tlb_bus.tlbp_req  = tlbp;
	assign tlb_bus.tlbwi_req = tlbwi;
	assign tlb_bus.tlbwr_req = tlbwr;

	assign epc    = regs.epc;
	assign status = regs.status.raw;
	assign cause  = regs.cause.raw;

	cp0 u_cp0 (
		.clk            (clk),
		.rst            (rst),
		.raddr          (raddr),
		.rsel           (rsel),
		.wreq           (wreq),
		.except_req_i   (except_req),
		.interrupt_flag (interrupt_flag),
		.tlb            (tlb_bus.cp0),
		.rdata          (rdata),
		.regs           (regs),
		.asid           (asid),
		.user_mode      (user_mode),
		.kseg0_uncached (kseg0_uncached),
		.timer_int      (timer_int)
	);

	tlb u_tlb (
		.clk          (clk),
		.rst          (rst),
		.bus          (tlb_bus.tlb),
		.asid         (asid),
		.lookup_valid (lookup_valid),
		.lookup_vaddr (lookup_vaddr),
		.lookup_paddr (lookup_paddr),
		.lookup_hit   (lookup_hit),
		.lookup_dirty (lookup_dirty)
	);

endmodule

`default_nettype wire

// ==== cp0_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cp0_defines.svh"

module cp0_sva (
	input logic                 clk,
	input logic                 rst,
	input cp0_pkg::cp0_req_t    wreq,
	input cp0_pkg::except_req_t except_req_i,
	input cp0_pkg::cp0_regs_t   regs,
	input logic                 timer_int
);

	localparam int TLB_WIDTH = $clog2(`TLB_ENTRIES_NUM);

	int fail_count = 0;

	timer_low_after_reset: assert property (@(posedge clk) $fell(rst) |-> !timer_int)
		else begin
			$error("timer_int high in the cycle after reset");
			fail_count++;
		end

	// request is registered first, then applied.
	exl_after_exception: assert property (@(posedge clk) disable iff (rst)
		except_req_i.valid && !except_req_i.eret |-> ##2 regs.status.f.exl)
		else begin
			$error("status.exl not set two cycles after an exception");
			fail_count++;
		end

	random_above_wired: assert property (@(posedge clk) disable iff (rst)
		regs.random[TLB_WIDTH-1:0] >= regs.wired[TLB_WIDTH-1:0])
		else begin
			$error("random fell below wired");
			fail_count++;
		end

	compare_clears_timer: assert property (@(posedge clk) disable iff (rst)
		wreq.we && wreq.wsel == 3'd0 && wreq.waddr == 5'd11 |=> !timer_int)
		else begin
			$error("timer_int still set after a compare write");
			fail_count++;
		end

endmodule

bind cp0 cp0_sva u_sva (
	.clk          (clk),
	.rst          (rst),
	.wreq         (wreq),
	.except_req_i (except_req_i),
	.regs         (regs),
	.timer_int    (timer_int)
);

`default_nettype wire

// ==== tb_cp0_tlb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cp0_defines.svh"

module tb_cp0_tlb;

	localparam int CLK_NS = 40;
	localparam int TEST_CYCLES = 5 + 15 + 100 + 60 + 60 + 60 + 100;
	localparam int WATCHDOG_NS = TEST_CYCLES * CLK_NS + 2000;
	localparam logic [31:0] TLB_MASK = `TLB_ENTRIES_NUM - 1;
	// mips config1 layout for 16 KB 2-way caches with 32-byte lines.
	localparam logic [31:0] CONFIG1_EXP = {1'b0, 6'(`TLB_ENTRIES_NUM - 1),
		3'd2, 3'd4, 3'd1, 3'd2, 3'd4, 3'd1, 7'd0};

	logic        clk;
	logic        rst;
	logic        we;
	logic [4:0]  waddr;
	logic [2:0]  wsel;
	logic [31:0] wdata;
	logic [4:0]  raddr;
	logic [2:0]  rsel;
	logic [31:0] rdata;
	logic        exc_valid;
	logic        exc_eret;
	logic        exc_delayslot;
	logic [4:0]  exc_code;
	logic [31:0] exc_pc;
	logic [31:0] exc_extra;
	logic [7:0]  interrupt_flag;
	logic        tlbr;
	logic        tlbp;
	logic        tlbwi;
	logic        tlbwr;
	logic        lookup_valid;
	logic [31:0] lookup_vaddr;
	logic [31:0] lookup_paddr;
	logic        lookup_hit;
	logic        lookup_dirty;
	logic        timer_int;
	logic [7:0]  asid;
	logic        user_mode;
	logic        kseg0_uncached;
	logic [31:0] epc;
	logic [31:0] status;
	logic [31:0] cause;
	integer      seed;

	cp0_tlb_top dut (.*);

	always #(CLK_NS / 2) clk = ~clk;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR: %s = 0x%08h, expected 0x%08h", name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [2:0] sel, input logic [31:0] data);
		we = 1'b1;
		waddr = addr;
		wsel = sel;
		wdata = data;
		@(negedge clk);
		we = 1'b0;
	endtask

	task automatic read_reg(input logic [4:0] addr, input logic [2:0] sel, output logic [31:0] data);
		raddr = addr;
		rsel = sel;
		@(negedge clk); // rdata is registered.
		data = rdata;
	endtask

	task automatic expect_reg(input string name, input logic [4:0] addr, input logic [2:0] sel,
		input logic [31:0] exp);
		logic [31:0] val;
		read_reg(addr, sel, val);
		check(name, val, exp);
	endtask

	task automatic write_expect(input string name, input logic [4:0] addr, input logic [2:0] sel,
		input logic [31:0] data, input logic [31:0] exp);
		write_reg(addr, sel, data);
		expect_reg(name, addr, sel, exp);
	endtask

	task automatic pulse_tlb(input logic [3:0] ops);
		{tlbr, tlbp, tlbwi, tlbwr} = ops;
		@(negedge clk);
		{tlbr, tlbp, tlbwi, tlbwr} = 4'b0000;
	endtask

	// effects are visible two cycles after the request.
	task automatic raise_exception(input logic eret, input logic ds, input logic [4:0] code,
		input logic [31:0] pc, input logic [31:0] extra);
		exc_valid = 1'b1;
		exc_eret = eret;
		exc_delayslot = ds;
		exc_code = code;
		exc_pc = pc;
		exc_extra = extra;
		@(negedge clk);
		exc_valid = 1'b0;
		@(negedge clk);
	endtask

	task automatic translate(input logic [31:0] vaddr, input logic exp_hit,
		input logic [31:0] exp_paddr, input logic exp_dirty);
		lookup_valid = 1'b1;
		lookup_vaddr = vaddr;
		@(negedge clk);
		check("lookup_hit", lookup_hit, exp_hit);
		if (exp_hit) begin
			check("lookup_paddr", lookup_paddr, exp_paddr);
			check("lookup_dirty", lookup_dirty, exp_dirty);
		end
		lookup_valid = 1'b0;
	endtask

	task automatic reset_values();
		check("timer_int", timer_int, 1'b0);
		check("lookup_hit", lookup_hit, 1'b0);
		check("rdata", rdata, 32'd0);
		expect_reg("status", 5'd12, 3'd0, `STATUS_RESET);
		expect_reg("prid", 5'd15, 3'd0, `PRID_RESET);
		expect_reg("random", 5'd1, 3'd0, TLB_MASK);
		expect_reg("ebase", 5'd15, 3'd1, `EBASE_RESET);
		expect_reg("config0", 5'd16, 3'd0, `CONFIG0_RESET);
	endtask

	task automatic register_masks();
		logic [31:0] w;
		w = $random(seed);
		write_expect("index", 5'd0, 3'd0, w, w & TLB_MASK);
		w = $random(seed);
		write_expect("entry_lo0", 5'd2, 3'd0, w, w & 32'h3fff_ffff);
		w = $random(seed);
		write_expect("entry_lo1", 5'd3, 3'd0, w, w & 32'h3fff_ffff);
		w = $random(seed);
		write_expect("context", 5'd4, 3'd0, w, w & 32'hff80_0000);
		write_expect("page_mask", 5'd5, 3'd0, $random(seed), 32'd0);
		w = $random(seed);
		write_expect("wired", 5'd6, 3'd0, w, w & TLB_MASK);
		write_expect("random", 5'd1, 3'd0, $random(seed), TLB_MASK); // reset by wired write.
		write_expect("unmapped reg 7", 5'd7, 3'd0, $random(seed), 32'd0);
		w = $random(seed);
		write_expect("entry_hi", 5'd10, 3'd0, w, w & 32'hffff_e0ff);
		w = $random(seed);
		write_expect("compare", 5'd11, 3'd0, w, w);
		w = $random(seed);
		write_expect("status", 5'd12, 3'd0, w, w & 32'h1040_ff17);
		w = $random(seed);
		write_expect("cause", 5'd13, 3'd0, w, w & 32'h0080_0300);
		w = $random(seed);
		write_expect("epc", 5'd14, 3'd0, w, w);
		write_expect("prid", 5'd15, 3'd0, $random(seed), `PRID_RESET);
		w = $random(seed);
		write_expect("config0", 5'd16, 3'd0, w, (`CONFIG0_RESET & ~32'h7) | (w & 32'h7));
		w = $random(seed);
		write_expect("ebase", 5'd15, 3'd1, w,
			(`EBASE_RESET & ~32'h3fff_f000) | (w & 32'h3fff_f000));
		write_expect("config1", 5'd16, 3'd1, $random(seed), CONFIG1_EXP);
		write_reg(5'd12, 3'd0, 32'h0000_0010); // um set, exl and erl clear.
		check("user_mode", user_mode, 1'b1);
		write_reg(5'd12, 3'd0, 32'h0000_0012);
		check("user_mode with exl", user_mode, 1'b0);
		write_reg(5'd16, 3'd0, 32'd2);
		check("kseg0_uncached", kseg0_uncached, 1'b1);
		write_reg(5'd16, 3'd0, 32'd3);
		check("kseg0_uncached", kseg0_uncached, 1'b0);
		write_reg(5'd12, 3'd0, `STATUS_RESET);
		write_reg(5'd13, 3'd0, 32'd0);
		write_reg(5'd11, 3'd0, 32'd0);
	endtask

	task automatic exception_entry();
		logic [31:0] ctx;
		logic [31:0] hi;
		raise_exception(1'b0, 1'b1, `EXCCODE_SYS, 32'hbfc0_0104, 32'd0);
		check("epc", epc, 32'hbfc0_0100);
		check("cause.bd", cause[31], 1'b1);
		check("status.exl", status[1], 1'b1);
		check("cause.exc_code", cause[6:2], `EXCCODE_SYS);
		raise_exception(1'b1, 1'b0, 5'd0, 32'd0, 32'd0);
		check("status.exl", status[1], 1'b0);
		read_reg(5'd4, 3'd0, ctx);
		read_reg(5'd10, 3'd0, hi);
		raise_exception(1'b0, 1'b0, `EXCCODE_TLBL, 32'h8000_1000, 32'h1234_5678);
		expect_reg("epc", 5'd14, 3'd0, 32'h8000_1000);
		check("cause.bd", cause[31], 1'b0);
		check("cause.exc_code", cause[6:2], `EXCCODE_TLBL);
		expect_reg("bad_vaddr", 5'd8, 3'd0, 32'h1234_5678);
		expect_reg("context", 5'd4, 3'd0, (ctx & 32'hff80_0000) | ((32'h1234_5678 >> 13) << 4));
		expect_reg("entry_hi", 5'd10, 3'd0, (hi & 32'h0000_1fff) | 32'h1234_4000);
		// nested entry keeps epc and bd.
		raise_exception(1'b0, 1'b1, `EXCCODE_ADEL, 32'h8000_2004, 32'h0000_0003);
		check("epc", epc, 32'h8000_1000);
		check("cause.bd", cause[31], 1'b0);
		check("cause.exc_code", cause[6:2], `EXCCODE_ADEL);
		expect_reg("bad_vaddr", 5'd8, 3'd0, 32'h0000_0003);
		raise_exception(1'b1, 1'b0, 5'd0, 32'd0, 32'd0);
		check("status.exl", status[1], 1'b0);
	endtask

	task automatic tlb_ops();
		write_reg(5'd10, 3'd0, 32'h0040_2005); // vpn2 0x201, asid 5.
		check("asid", asid, 8'h05);
		write_reg(5'd2, 3'd0, {2'b00, 24'h012345, 3'd3, 1'b1, 1'b1, 1'b0});
		write_reg(5'd3, 3'd0, {2'b00, 24'h00abcd, 3'd2, 1'b0, 1'b1, 1'b0});
		write_reg(5'd0, 3'd0, 32'd3);
		pulse_tlb(4'b0010);
		write_reg(5'd0, 3'd0, 32'd0);
		pulse_tlb(4'b0100);
		expect_reg("index after probe hit", 5'd0, 3'd0, 32'd3);
		write_reg(5'd10, 3'd0, 32'h7fff_e005);
		pulse_tlb(4'b0100);
		expect_reg("index after probe miss", 5'd0, 3'd0, 32'h8000_0000);
		write_reg(5'd2, 3'd0, 32'd0);
		write_reg(5'd3, 3'd0, 32'd0);
		write_reg(5'd0, 3'd0, 32'd3);
		pulse_tlb(4'b1000);
		expect_reg("entry_lo0", 5'd2, 3'd0, {2'b00, 24'h012345, 3'd3, 1'b1, 1'b1, 1'b0});
		expect_reg("entry_lo1", 5'd3, 3'd0, {2'b00, 24'h00abcd, 3'd2, 1'b0, 1'b1, 1'b0});
		expect_reg("entry_hi", 5'd10, 3'd0, 32'h0040_2005);
		translate(32'h0040_2abc, 1'b1, 32'h1234_5abc, 1'b1);
		translate(32'h0040_3def, 1'b1, 32'h0abc_ddef, 1'b0);
		write_reg(5'd10, 3'd0, 32'h0040_2006);
		check("asid", asid, 8'h06);
		translate(32'h0040_2abc, 1'b0, 32'd0, 1'b0);
		write_reg(5'd10, 3'd0, 32'h0040_2005);
	endtask

	task automatic tlb_random_write();
		write_reg(5'd6, 3'd0, 32'd4);
		expect_reg("random after wired write", 5'd1, 3'd0, TLB_MASK);
		write_reg(5'd10, 3'd0, 32'h0060_0005);
		write_reg(5'd2, 3'd0, {2'b00, 24'h000111, 3'd2, 1'b0, 1'b1, 1'b0});
		write_reg(5'd3, 3'd0, 32'd0);
		pulse_tlb(4'b0001);
		expect_reg("random after wrap", 5'd1, 3'd0, 32'd4);
		translate(32'h0060_0010, 1'b1, 32'h0011_1010, 1'b0);
		write_reg(5'd10, 3'd0, 32'h0080_0005);
		write_reg(5'd2, 3'd0, {2'b00, 24'h000222, 3'd2, 1'b1, 1'b1, 1'b0});
		pulse_tlb(4'b0001);
		expect_reg("random after step", 5'd1, 3'd0, 32'd5);
		translate(32'h0080_0020, 1'b1, 32'h0022_2020, 1'b1);
		translate(32'h0040_2abc, 1'b1, 32'h1234_5abc, 1'b1); // wired entry kept.
		write_reg(5'd0, 3'd0, TLB_MASK);
		pulse_tlb(4'b1000);
		expect_reg("entry_hi of top entry", 5'd10, 3'd0, 32'h0060_0005);
	endtask

	task automatic timer_and_irq();
		int waited;
		write_reg(5'd9, 3'd0, 32'h0000_0100);
		write_reg(5'd11, 3'd0, 32'h0000_0110);
		waited = 0;
		while (!timer_int && waited < 2 * 16 + 4) begin // count steps every two clocks.
			@(negedge clk);
			waited++;
		end
		check("timer_int", timer_int, 1'b1);
		repeat (3) @(negedge clk);
		check("timer_int held", timer_int, 1'b1);
		write_reg(5'd11, 3'd0, 32'd0);
		check("timer_int after clear", timer_int, 1'b0);
		interrupt_flag = 8'ha5;
		@(negedge clk);
		check("cause.ip[7:2]", cause[15:10], 8'ha5 >> 2);
		interrupt_flag = 8'h00;
		@(negedge clk);
		check("cause.ip[7:2]", cause[15:10], 6'd0);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		seed = 32'h188b_c71d;
		clk = 1'b0;
		rst = 1'b1;
		{we, waddr, wsel, wdata, raddr, rsel} = '0;
		{exc_valid, exc_eret, exc_delayslot, exc_code, exc_pc, exc_extra} = '0;
		interrupt_flag = 8'h00;
		{tlbr, tlbp, tlbwi, tlbwr} = 4'b0000;
		lookup_valid = 1'b0;
		lookup_vaddr = 32'd0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		reset_values();
		register_masks();
		exception_entry();
		tlb_ops();
		tlb_random_write();
		timer_and_irq();
		if (dut.u_cp0.u_sva.fail_count != 0) begin
			$display("%0d assertion failures were reported", dut.u_cp0.u_sva.fail_count);
			$display("TESTBENCH FAILED");
			$fatal(1, "assertion failures");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
cp0_pkg.sv
cp0_tlb_if.sv
cp0.sv
tlb.sv
cp0_tlb_top.sv
cp0_sva.sv
tb_cp0_tlb.sv

// ==== Bender.yml ====
package:
  name: cp0_tlb

sources:
  - include_dirs:
      - .
    files:
      - cp0_pkg.sv
      - cp0_tlb_if.sv
      - cp0.sv
      - tlb.sv
      - cp0_tlb_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - cp0_sva.sv
      - tb_cp0_tlb.sv
